// ==== rtl/openadc_pkg.sv ====
package openadc_pkg;

   // host bus geometry
   localparam int BYTECNT_W = 7;

   // register widths in bits
   localparam int GAIN_W       = 8;
   localparam int SETTINGS_W   = 8;
   localparam int ECHO_W       = 64;
   localparam int SAMPLES_W    = 32;
   localparam int PRESAMPLES_W = 15;
   localparam int OFFSET_W     = 32;
   localparam int DECIMATE_W   = 13;
   localparam int TRIG_LEVEL_W = 12;

   localparam int INTERVAL_WIDTH = 32;   // one trigger-to-trigger distance

   // register map
   localparam logic [7:0] GAIN_ADDR              = 8'd0;
   localparam logic [7:0] SETTINGS_ADDR          = 8'd1;
   localparam logic [7:0] STATUS_ADDR            = 8'd2;
   localparam logic [7:0] ECHO_ADDR              = 8'd4;
   localparam logic [7:0] DECIMATE_ADDR          = 8'd15;
   localparam logic [7:0] SAMPLES_ADDR           = 8'd16;
   localparam logic [7:0] PRESAMPLES_ADDR        = 8'd17;
   localparam logic [7:0] OFFSET_ADDR            = 8'd26;
   localparam logic [7:0] TRIG_LEVEL_ADDR        = 8'd36;
   localparam logic [7:0] NUM_TRIGGERS_DATA_ADDR = 8'd42;
   localparam logic [7:0] NUM_TRIGGERS_STAT_ADDR = 8'd43;

   // rising-edge trigger, trigger wait on
   localparam logic [SETTINGS_W-1:0] SETTINGS_DEFAULT = 8'h24;

   // settings register bits
   localparam int SET_SOFT_RESET_BIT = 0;   // self-clearing
   localparam int SET_TRIG_MODE_BIT  = 2;
   localparam int SET_ARM_BIT        = 3;
   localparam int SET_STREAM_BIT     = 4;
   localparam int SET_WAIT_BIT       = 5;
   localparam int SET_NOW_BIT        = 6;

   typedef logic [INTERVAL_WIDTH-1:0] interval_t;

   typedef struct packed {
      logic [7:0]           address;
      logic [BYTECNT_W-1:0] bytecnt;   // byte lane of a wide register
      logic [7:0]           wdata;
      logic                 read;      // single-cycle strobe
      logic                 write;     // single-cycle strobe
   } reg_bus_t;

   // configuration handed to the capture logic
   typedef struct packed {
      logic [GAIN_W-1:0]       gain;
      logic                    trigger_mode;
      logic                    fifo_stream;
      logic                    trigger_wait;
      logic                    trigger_now;
      logic [TRIG_LEVEL_W-1:0] trigger_level;
      logic [OFFSET_W-1:0]     trigger_offset;
      logic [SAMPLES_W-1:0]    samples;
      logic [PRESAMPLES_W-1:0] presamples;
      logic [DECIMATE_W-1:0]   downsample;
   } capture_cfg_t;

endpackage

// ==== rtl/adc_reg_ctrl.sv ====
`timescale 1ns/1ps

module adc_reg_ctrl import openadc_pkg::*; (
   input  logic         adc_sampleclk,
   input  logic         reset_i,        // combined hard and soft reset
   input  reg_bus_t     reg_bus_i,
   input  logic [7:0]   status_i,
   input  interval_t    fifo_head_i,
   input  logic         fifo_empty_i,
   input  logic         overflow_i,
   input  logic         underflow_i,
   output logic [7:0]   reg_data_o,
   output capture_cfg_t cfg_o,
   output logic         arm_req_o,
   output logic         soft_reset_o,
   output logic         fifo_pop_o,
   output logic         flag_clear_o
);

   logic [GAIN_W-1:0]       gain_q;
   logic [SETTINGS_W-1:0]   settings_q;
   logic [ECHO_W-1:0]       echo_q;
   logic [SAMPLES_W-1:0]    samples_q;
   logic [PRESAMPLES_W-1:0] presamples_q;
   logic [OFFSET_W-1:0]     offset_q;
   logic [DECIMATE_W-1:0]   decimate_q;
   logic [TRIG_LEVEL_W-1:0] trig_level_q;
   logic                    fifo_pop_q;
   logic                    flag_clear_q;
   logic [7:0]              fifo_status;
   logic [BYTECNT_W-1:0]    lane;

   assign lane = reg_bus_i.bytecnt;

   // drop one byte into a register image, lanes past 7 are ignored
   function automatic logic [63:0] byte_merge(input logic [63:0]          cur,
                                              input logic [BYTECNT_W-1:0] idx,
                                              input logic [7:0]           data);
      logic [63:0] res;
      res = cur;
      if (idx[BYTECNT_W-1:3] == '0)
         res[{idx[2:0], 3'b000} +: 8] = data;
      return res;
   endfunction

   function automatic logic [7:0] byte_pick(input logic [63:0]          cur,
                                            input logic [BYTECNT_W-1:0] idx);
      logic [7:0] res;
      res = 8'h00;
      if (idx[BYTECNT_W-1:3] == '0)
         res = cur[{idx[2:0], 3'b000} +: 8];
      return res;
   endfunction

   // truncation on the way back drops bytes beyond each register's width
   always_ff @(posedge adc_sampleclk) begin
      if (reset_i) begin
         gain_q       <= '0;
         settings_q   <= SETTINGS_DEFAULT;
         echo_q       <= '0;
         samples_q    <= '0;
         presamples_q <= '0;
         offset_q     <= '0;
         decimate_q   <= '0;
         trig_level_q <= '0;
         fifo_pop_q   <= 1'b0;
         flag_clear_q <= 1'b0;
      end else begin
         fifo_pop_q   <= reg_bus_i.write && (reg_bus_i.address == NUM_TRIGGERS_DATA_ADDR);
         flag_clear_q <= reg_bus_i.write && (reg_bus_i.address == NUM_TRIGGERS_STAT_ADDR);
         if (reg_bus_i.write) begin
            case (reg_bus_i.address)
               GAIN_ADDR:
                  gain_q <= GAIN_W'(byte_merge(64'(gain_q), lane, reg_bus_i.wdata));
               SETTINGS_ADDR:
                  settings_q <= SETTINGS_W'(byte_merge(64'(settings_q), lane,
                                                       reg_bus_i.wdata));
               ECHO_ADDR:
                  echo_q <= byte_merge(echo_q, lane, reg_bus_i.wdata);
               SAMPLES_ADDR:
                  samples_q <= SAMPLES_W'(byte_merge(64'(samples_q), lane, reg_bus_i.wdata));
               PRESAMPLES_ADDR:
                  presamples_q <= PRESAMPLES_W'(byte_merge(64'(presamples_q), lane,
                                                           reg_bus_i.wdata));
               OFFSET_ADDR:
                  offset_q <= OFFSET_W'(byte_merge(64'(offset_q), lane, reg_bus_i.wdata));
               DECIMATE_ADDR:
                  decimate_q <= DECIMATE_W'(byte_merge(64'(decimate_q), lane,
                                                       reg_bus_i.wdata));
               TRIG_LEVEL_ADDR:
                  trig_level_q <= TRIG_LEVEL_W'(byte_merge(64'(trig_level_q), lane,
                                                           reg_bus_i.wdata));
               default: ;   // read-only or unmapped
            endcase
         end
      end
   end

   assign fifo_status = {5'b0, underflow_i, overflow_i, fifo_empty_i};

   // readback, combinational and zero outside a read
   always_comb begin
      reg_data_o = 8'h00;
      if (reg_bus_i.read) begin
         case (reg_bus_i.address)
            GAIN_ADDR:       reg_data_o = byte_pick(64'(gain_q), lane);
            SETTINGS_ADDR:   reg_data_o = byte_pick(64'(settings_q), lane);
            STATUS_ADDR:     reg_data_o = byte_pick(64'(status_i), lane);
            ECHO_ADDR:       reg_data_o = byte_pick(echo_q, lane);
            SAMPLES_ADDR:    reg_data_o = byte_pick(64'(samples_q), lane);
            PRESAMPLES_ADDR: reg_data_o = byte_pick(64'(presamples_q), lane);
            OFFSET_ADDR:     reg_data_o = byte_pick(64'(offset_q), lane);
            DECIMATE_ADDR:   reg_data_o = byte_pick(64'(decimate_q), lane);
            TRIG_LEVEL_ADDR: reg_data_o = byte_pick(64'(trig_level_q), lane);
            NUM_TRIGGERS_DATA_ADDR:
               if (!fifo_empty_i)
                  reg_data_o = byte_pick(64'(fifo_head_i), lane);
            NUM_TRIGGERS_STAT_ADDR: reg_data_o = byte_pick(64'(fifo_status), lane);
            default:         reg_data_o = 8'h00;
         endcase
      end
   end

   always_comb begin
      cfg_o.gain           = gain_q;
      cfg_o.trigger_mode   = settings_q[SET_TRIG_MODE_BIT];
      cfg_o.fifo_stream    = settings_q[SET_STREAM_BIT];
      cfg_o.trigger_wait   = settings_q[SET_WAIT_BIT];
      cfg_o.trigger_now    = settings_q[SET_NOW_BIT];
      cfg_o.trigger_level  = trig_level_q;
      cfg_o.trigger_offset = offset_q;
      cfg_o.samples        = samples_q;
      cfg_o.presamples     = presamples_q;
      cfg_o.downsample     = decimate_q;
   end

   assign arm_req_o    = settings_q[SET_ARM_BIT];
   assign soft_reset_o = settings_q[SET_SOFT_RESET_BIT];   // clears itself via reset_i
   assign fifo_pop_o   = fifo_pop_q;
   assign flag_clear_o = flag_clear_q;

   // host never issues read and write in the same cycle
   a_rd_wr_exclusive: assert property (@(posedge adc_sampleclk) disable iff (reset_i)
      !(reg_bus_i.read && reg_bus_i.write));

endmodule

// ==== rtl/arm_pipeline.sv ====
`timescale 1ns/1ps

module arm_pipeline import openadc_pkg::*; #(
   parameter int ARM_STAGES = 4
) (
   input  logic adc_sampleclk,
   input  logic reset_i,
   input  logic arm_req_i,
   output logic cmd_arm_o,
   output logic arm_rise_o
);

   logic [ARM_STAGES-1:0] arm_q;
   logic                  cmd_arm_q;   // last stage, one cycle late

   always_ff @(posedge adc_sampleclk) begin
      if (reset_i) begin
         arm_q     <= '0;
         cmd_arm_q <= 1'b0;
      end else begin
         arm_q     <= {arm_q[ARM_STAGES-2:0], arm_req_i};
         cmd_arm_q <= arm_q[ARM_STAGES-1];
      end
   end

   assign cmd_arm_o = arm_q[ARM_STAGES-1];

   // one cycle high as the ADC-side arm goes up
   assign arm_rise_o = arm_q[ARM_STAGES-1] & ~cmd_arm_q;

endmodule

// ==== rtl/trigger_interval_counter.sv ====
`timescale 1ns/1ps

module trigger_interval_counter import openadc_pkg::*; (
   input  logic      adc_sampleclk,
   input  logic      reset_i,
   input  logic      trigger_event_i,
   input  logic      arm_rise_i,
   input  logic      flag_clear_i,
   input  logic      fifo_pop_i,
   input  logic      fifo_full_i,
   input  logic      fifo_empty_i,
   output logic      push_o,
   output interval_t push_data_o,
   output logic      overflow_o,
   output logic      underflow_o
);

   logic      trig_q;
   logic      trig_edge;
   logic      take;          // edge that fits in the FIFO
   interval_t count_q;
   interval_t push_data_q;
   logic      push_q;
   logic      overflow_q;
   logic      underflow_q;

   assign trig_edge = trigger_event_i & ~trig_q;
   assign take      = trig_edge & ~fifo_full_i;

   always_ff @(posedge adc_sampleclk) begin
      if (reset_i) begin
         trig_q      <= 1'b0;
         count_q     <= interval_t'(1);   // keeps the first interval nonzero
         push_q      <= 1'b0;
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         trig_q <= trigger_event_i;
         push_q <= take;
         if (take)
            count_q <= interval_t'(1);
         else if (count_q != '1)
            count_q <= count_q + 1'b1;   // saturate at all ones

         // clear wins over a set in the same cycle
         if (flag_clear_i || arm_rise_i) begin
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
         end else begin
            if (trig_edge && fifo_full_i)
               overflow_q <= 1'b1;
            if (fifo_pop_i && fifo_empty_i)
               underflow_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge adc_sampleclk) begin
      if (take)
         push_data_q <= count_q;
   end

   assign push_o      = push_q;
   assign push_data_o = push_data_q;
   assign overflow_o  = overflow_q;
   assign underflow_o = underflow_q;

   // full is sampled one cycle ahead of the push, edges are never back to back
   a_no_push_when_full: assert property (@(posedge adc_sampleclk) disable iff (reset_i)
      push_o |-> !fifo_full_i);

endmodule

// ==== rtl/interval_fifo.sv ====
`timescale 1ns/1ps

module interval_fifo import openadc_pkg::*; #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic      adc_sampleclk,
   input  logic      reset_i,
   input  logic      flush_i,
   input  logic      push_i,
   input  interval_t push_data_i,
   input  logic      pop_i,
   output interval_t head_o,
   output logic      full_o,
   output logic      empty_o
);

   localparam int AW = $clog2(FIFO_DEPTH);
   localparam logic [AW:0] FULL_LEVEL = 1'b1 << AW;

   interval_t   mem [FIFO_DEPTH];
   logic [AW:0] wr_ptr_q;   // extra msb tells full from empty
   logic [AW:0] rd_ptr_q;
   logic [AW:0] level;
   logic        wr_en;
   logic        rd_en;

   assign level   = wr_ptr_q - rd_ptr_q;
   assign full_o  = (level == FULL_LEVEL);
   assign empty_o = (level == '0);

   // flush beats both, pop on empty is dropped
   assign wr_en = push_i & ~full_o & ~flush_i;
   assign rd_en = pop_i & ~empty_o & ~flush_i;

   always_ff @(posedge adc_sampleclk) begin
      if (reset_i || flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_en)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_en)
            rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge adc_sampleclk) begin
      if (wr_en)
         mem[wr_ptr_q[AW-1:0]] <= push_data_i;
   end

   // show-ahead, oldest entry always on the output
   assign head_o = mem[rd_ptr_q[AW-1:0]];

   a_level_in_range: assert property (@(posedge adc_sampleclk) disable iff (reset_i)
      level <= FULL_LEVEL);

endmodule

// ==== rtl/openadc_reg_top.sv ====
`timescale 1ns/1ps

module openadc_reg_top import openadc_pkg::*; #(
   parameter int FIFO_DEPTH = 16,   // power of two
   parameter int ARM_STAGES = 4     // at least 2
) (
   input  logic         adc_sampleclk,
   input  logic         reset,
   input  reg_bus_t     reg_bus_i,
   input  logic [7:0]   status_i,
   input  logic         trigger_event_i,
   output logic [7:0]   reg_data_o,
   output capture_cfg_t cfg_o,
   output logic         cmd_arm_o,
   output logic         reset_o
);

   logic      rst_all;
   logic      soft_reset;
   logic      arm_req;
   logic      arm_rise;
   logic      fifo_pop;
   logic      flag_clear;
   logic      push;
   interval_t push_data;
   interval_t fifo_head;
   logic      fifo_full;
   logic      fifo_empty;
   logic      overflow;
   logic      underflow;

   // soft reset bit takes the whole block down for one cycle
   assign rst_all = reset | soft_reset;
   assign reset_o = rst_all;

   adc_reg_ctrl ctrl_i (
      .adc_sampleclk (adc_sampleclk),
      .reset_i       (rst_all),
      .reg_bus_i     (reg_bus_i),
      .status_i      (status_i),
      .fifo_head_i   (fifo_head),
      .fifo_empty_i  (fifo_empty),
      .overflow_i    (overflow),
      .underflow_i   (underflow),
      .reg_data_o    (reg_data_o),
      .cfg_o         (cfg_o),
      .arm_req_o     (arm_req),
      .soft_reset_o  (soft_reset),
      .fifo_pop_o    (fifo_pop),
      .flag_clear_o  (flag_clear)
   );

   arm_pipeline #(.ARM_STAGES(ARM_STAGES)) arm_i (
      .adc_sampleclk (adc_sampleclk),
      .reset_i       (rst_all),
      .arm_req_i     (arm_req),
      .cmd_arm_o     (cmd_arm_o),
      .arm_rise_o    (arm_rise)
   );

   trigger_interval_counter counter_i (
      .adc_sampleclk   (adc_sampleclk),
      .reset_i         (rst_all),
      .trigger_event_i (trigger_event_i),
      .arm_rise_i      (arm_rise),
      .flag_clear_i    (flag_clear),
      .fifo_pop_i      (fifo_pop),
      .fifo_full_i     (fifo_full),
      .fifo_empty_i    (fifo_empty),
      .push_o          (push),
      .push_data_o     (push_data),
      .overflow_o      (overflow),
      .underflow_o     (underflow)
   );

   interval_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
      .adc_sampleclk (adc_sampleclk),
      .reset_i       (rst_all),
      .flush_i       (arm_rise),   // emptied on every new arm
      .push_i        (push),
      .push_data_i   (push_data),
      .pop_i         (fifo_pop),
      .head_o        (fifo_head),
      .full_o        (fifo_full),
      .empty_o       (fifo_empty)
   );

endmodule

// ==== verif/tb_openadc_reg.sv ====
`timescale 1ns/1ps

module tb_openadc_reg import openadc_pkg::*; ();

   logic         adc_sampleclk;
   logic         reset;
   reg_bus_t     reg_bus;
   logic [7:0]   status_in;
   logic         trigger_event;
   logic [7:0]   reg_data;
   capture_cfg_t cfg;
   logic         cmd_arm;
   logic         reset_out;

   logic [7:0]   ref_settings;           // model of the settings register
   logic [63:0]  refv [256];             // model of the byte-lane registers
   logic [3:0]   arm_hist;               // settings arm bit, four cycles of history
   int unsigned  lcg_state;
   int unsigned  cyc;
   int unsigned  last_edge;
   int unsigned  gaps [$];               // expected intervals, oldest first
   logic         exp_rst;

   openadc_reg_top #(.FIFO_DEPTH(8), .ARM_STAGES(4)) dut_i (
      .adc_sampleclk   (adc_sampleclk),
      .reset           (reset),
      .reg_bus_i       (reg_bus),
      .status_i        (status_in),
      .trigger_event_i (trigger_event),
      .reg_data_o      (reg_data),
      .cfg_o           (cfg),
      .cmd_arm_o       (cmd_arm),
      .reset_o         (reset_out)
   );

   initial begin
      adc_sampleclk = 1'b0;
      forever #10 adc_sampleclk = ~adc_sampleclk;
   end

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic fail_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
      stop_with_error($sformatf("Fail %s expected %h got %h", name, exp, act));
   endtask

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   function automatic int width_of(input logic [7:0] addr);
      case (addr)
         GAIN_ADDR:       return 8;
         ECHO_ADDR:       return 64;
         SAMPLES_ADDR:    return 32;
         PRESAMPLES_ADDR: return 15;
         OFFSET_ADDR:     return 32;
         DECIMATE_ADDR:   return 13;
         TRIG_LEVEL_ADDR: return 12;
         default:         return 0;
      endcase
   endfunction

   // every posedge, the model settings follow the bus and the reset rule
   always @(posedge adc_sampleclk) begin
      cyc <= cyc + 1;
      if (cyc > 6000)
         stop_with_error("timeout, the test did not finish within 6000 cycles");
      if (reset || ref_settings[0])
         ref_settings <= 8'h24;
      else if (reg_bus.write && reg_bus.address == SETTINGS_ADDR && reg_bus.bytecnt == 0)
         ref_settings <= reg_bus.wdata;
   end

   assign exp_rst = reset | ref_settings[0];

   a_reset_out: assert property (@(posedge adc_sampleclk) reset_out == exp_rst)
      else fail_value("reset_o", 128'(exp_rst), 128'(reset_out));

   // cmd_arm follows the arm bit four cycles late
   always @(negedge adc_sampleclk) begin
      assert (cmd_arm == arm_hist[3])
         else fail_value("cmd_arm_o", 128'(arm_hist[3]), 128'(cmd_arm));
      if (exp_rst)
         arm_hist <= '0;
      else
         arm_hist <= {arm_hist[2:0], ref_settings[SET_ARM_BIT]};
   end

   task automatic step();
      @(posedge adc_sampleclk);
      #2;
   endtask

   task automatic idle(input int n);
      repeat (n) step();
   endtask

   task automatic write_byte(input logic [7:0] addr, input int idx, input logic [7:0] data);
      reg_bus.address = addr;
      reg_bus.bytecnt = BYTECNT_W'(idx);
      reg_bus.wdata   = data;
      reg_bus.write   = 1'b1;
      step();
      reg_bus.write   = 1'b0;
   endtask

   task automatic read_byte(input logic [7:0] addr, input int idx, output logic [7:0] data);
      reg_bus.address = addr;
      reg_bus.bytecnt = BYTECNT_W'(idx);
      reg_bus.read    = 1'b1;
      #8;                                // mid cycle, read data settled
      data = reg_data;
      step();
      reg_bus.read    = 1'b0;
   endtask

   task automatic expect_byte(input logic [7:0] addr, input int idx, input logic [7:0] exp,
                              input string name);
      logic [7:0] got;
      read_byte(addr, idx, got);
      assert (got == exp) else fail_value(name, 128'(exp), 128'(got));
   endtask

   task automatic read_word(input logic [7:0] addr, output logic [31:0] w);
      logic [7:0] b;
      for (int i = 0; i < 4; i++) begin
         read_byte(addr, i, b);
         w[8*i +: 8] = b;
      end
   endtask

   task automatic check_regs();
      logic [7:0] exp;
      capture_cfg_t ecfg;
      foreach (refv[a]) begin
         if (width_of(8'(a)) != 0) begin
            for (int i = 0; i < 10; i++) begin
               exp = (i < 8) ? refv[a][8*i +: 8] : 8'h00;
               expect_byte(8'(a), i, exp, $sformatf("reg_data_o addr %0d byte %0d", a, i));
            end
         end
      end
      expect_byte(SETTINGS_ADDR, 0, ref_settings, "reg_data_o settings");
      ecfg.gain           = refv[GAIN_ADDR][7:0];
      ecfg.trigger_mode   = ref_settings[SET_TRIG_MODE_BIT];
      ecfg.fifo_stream    = ref_settings[SET_STREAM_BIT];
      ecfg.trigger_wait   = ref_settings[SET_WAIT_BIT];
      ecfg.trigger_now    = ref_settings[SET_NOW_BIT];
      ecfg.trigger_level  = refv[TRIG_LEVEL_ADDR][11:0];
      ecfg.trigger_offset = refv[OFFSET_ADDR][31:0];
      ecfg.samples        = refv[SAMPLES_ADDR][31:0];
      ecfg.presamples     = refv[PRESAMPLES_ADDR][14:0];
      ecfg.downsample     = refv[DECIMATE_ADDR][12:0];
      assert (cfg == ecfg) else fail_value("cfg_o", 128'(ecfg), 128'(cfg));
   endtask

   // one-cycle trigger high, next pulse gap cycles later
   task automatic trig_pulse(input int gap);
      if (last_edge != 0)
         gaps.push_back(cyc - last_edge);
      last_edge = cyc;
      trigger_event = 1'b1;
      step();
      trigger_event = 1'b0;
      idle(gap - 1);
   endtask

   task automatic pop_entry();
      write_byte(NUM_TRIGGERS_DATA_ADDR, 0, 8'h00);
      idle(2);
   endtask

   initial begin
      logic [31:0] w;
      logic [7:0]  d;
      int          wid;
      reset         = 1'b1;
      reg_bus       = '0;
      status_in     = 8'h00;
      trigger_event = 1'b0;
      ref_settings  = 8'h24;
      arm_hist      = '0;
      cyc           = 0;
      last_edge     = 0;
      lcg_state     = 68963;
      foreach (refv[a])
         refv[a] = '0;
      repeat (3) @(posedge adc_sampleclk);
      #2;
      reset = 1'b0;

      // reset values
      check_regs();
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h01, "fifo status after reset");

      // byte-lane registers, random bytes including lanes past the width
      foreach (refv[a]) begin
         wid = width_of(8'(a));
         if (wid != 0) begin
            for (int i = 0; i < 9; i++) begin
               d = 8'(lcg_next());
               write_byte(8'(a), i, d);
               if (i < 8)
                  refv[a][8*i +: 8] = d;
            end
            if (wid < 64)
               refv[a] = refv[a] & ((64'd1 << wid) - 1);
         end
      end
      write_byte(SETTINGS_ADDR, 0, 8'h74);
      check_regs();
      write_byte(SETTINGS_ADDR, 0, 8'h24);
      status_in = 8'(lcg_next());
      expect_byte(STATUS_ADDR, 0, status_in, "status readback");
      expect_byte(STATUS_ADDR, 1, 8'h00, "status upper byte");

      // interval readback
      for (int n = 0; n < 6; n++)
         trig_pulse(3 + int'(lcg_next() % 20));
      idle(4);
      read_word(NUM_TRIGGERS_DATA_ADDR, w);
      assert (w != 0) else stop_with_error("first interval read as zero");
      pop_entry();
      while (gaps.size() > 0) begin
         read_word(NUM_TRIGGERS_DATA_ADDR, w);
         assert (w == gaps[0]) else fail_value("interval", 128'(gaps[0]), 128'(w));
         void'(gaps.pop_front());
         pop_entry();
      end
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h01, "fifo status drained");

      // overflow, underflow and clear
      for (int n = 0; n < 9; n++)
         trig_pulse(4);
      idle(4);
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h02, "fifo status overflow");
      for (int n = 0; n < 8; n++)
         pop_entry();
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h03, "fifo status empty");
      pop_entry();
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h07, "fifo status underflow");
      write_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h00);
      idle(2);
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h01, "fifo status cleared");

      // arm flushes queued entries and flags
      pop_entry();
      for (int n = 0; n < 9; n++)
         trig_pulse(4);
      idle(4);
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h06, "fifo status before arm");
      write_byte(SETTINGS_ADDR, 0, 8'h2c);
      idle(7);
      assert (cmd_arm == 1'b1) else fail_value("cmd_arm_o", 128'(1), 128'(cmd_arm));
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h01, "fifo status after arm");
      write_byte(SETTINGS_ADDR, 0, 8'h24);
      idle(6);

      // soft reset, with the FIFO full and overflow set
      for (int n = 0; n < 9; n++)
         trig_pulse(4);
      write_byte(SETTINGS_ADDR, 0, 8'h01);
      assert (reset_out == 1'b1) else fail_value("reset_o", 128'(1), 128'(reset_out));
      step();
      foreach (refv[a])
         refv[a] = '0;
      gaps.delete();
      check_regs();
      expect_byte(NUM_TRIGGERS_STAT_ADDR, 0, 8'h01, "fifo status after soft reset");

      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== vlog.f ====
rtl/openadc_pkg.sv
rtl/adc_reg_ctrl.sv
rtl/arm_pipeline.sv
rtl/trigger_interval_counter.sv
rtl/interval_fifo.sv
rtl/openadc_reg_top.sv
verif/tb_openadc_reg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the register block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
   --top-module tb_openadc_reg \
   -f vlog.f

# a $fatal in the testbench gives a nonzero exit status here
./obj_dir/Vtb_openadc_reg
